/* vlog.f */
cpu_pkg.sv
hazard_if.sv
pipeline_reg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
cpu_top.sv
tb_cpu_sva.sv
tb_cpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f vlog.f -o sim_cpu

# an assertion stop also shows up as a missing pass line in the log
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	localparam word_t PROG_BASE = 32'h0000_0040;
	localparam int N_TESTS = 4;
	localparam int MAX_LEN = 16;
	localparam int MAX_RET = 16;
	localparam int START_TIMEOUT = 10;
	localparam int RETIRE_TIMEOUT = 200;
	localparam int QUIET_CYCLES = 30;

	logic clock;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	word_t wb_adr;
	word_t wb_dat_i;
	logic wb_ack;
	logic retire_valid;
	reg_idx_t retire_rd;
	word_t retire_data;

	string test_name [N_TESTS];
	word_t prog [N_TESTS][MAX_LEN];
	int prog_len [N_TESTS];
	reg_idx_t exp_rd [N_TESTS][MAX_RET];
	word_t exp_data [N_TESTS][MAX_RET];
	int exp_cnt [N_TESTS];
	int cur_test = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int checks = 0;
	int errors = 0;

	cpu_top #(
		.RESET_PC(PROG_BASE)
	) DUT (
		.clock(clock),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic word_t encode(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
			logic [15:0] imm);
		return {op, rd, rs, rt, imm};
	endfunction

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// past the program the memory holds NOPs whose low bits follow the address
	function automatic word_t mem_word(int t, word_t adr);
		word_t off;
		off = adr - PROG_BASE;
		if (off < 32'(MAX_LEN) && int'(off) < prog_len[t]) begin
			return prog[t][int'(off)];
		end
		return {4'h0, adr[27:0] ^ {24'h0, adr[31:28]}};
	endfunction

	task automatic put_instr(input int t, input word_t w);
		prog[t][prog_len[t]] = w;
		prog_len[t]++;
	endtask

	task automatic expect_retire(input int t, input reg_idx_t rd, input word_t data);
		exp_rd[t][exp_cnt[t]] = rd;
		exp_data[t][exp_cnt[t]] = data;
		exp_cnt[t]++;
	endtask

	task automatic build_tables();
		for (int t = 0; t < N_TESTS; t++) begin
			prog_len[t] = 0;
			exp_cnt[t] = 0;
		end
		test_name[0] = "alu ops";
		put_instr(0, encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h1234));
		put_instr(0, encode(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'hfff0));
		put_instr(0, encode(OP_LUI, 4'd3, 4'd0, 4'd0, 16'habcd));
		put_instr(0, encode(OP_ADD, 4'd4, 4'd1, 4'd2, 16'h0000));
		put_instr(0, encode(OP_SUB, 4'd5, 4'd1, 4'd2, 16'h0000));
		put_instr(0, encode(OP_AND, 4'd6, 4'd3, 4'd2, 16'h0000));
		put_instr(0, encode(OP_OR, 4'd7, 4'd1, 4'd3, 16'h0000));
		put_instr(0, encode(OP_XOR, 4'd8, 4'd7, 4'd2, 16'h0000));
		put_instr(0, encode(OP_NOP, 4'd0, 4'd0, 4'd0, 16'h0000));
		put_instr(0, encode(OP_ADD, 4'd0, 4'd1, 4'd1, 16'h0000));   // r0 keeps zero
		put_instr(0, encode(OP_ADD, 4'd9, 4'd0, 4'd1, 16'h0000));
		expect_retire(0, 4'd1, 32'h0000_1234);
		expect_retire(0, 4'd2, 32'hffff_fff0);
		expect_retire(0, 4'd3, 32'habcd_0000);
		expect_retire(0, 4'd4, 32'h0000_1224);
		expect_retire(0, 4'd5, 32'h0000_1244);
		expect_retire(0, 4'd6, 32'habcd_0000);
		expect_retire(0, 4'd7, 32'habcd_1234);
		expect_retire(0, 4'd8, 32'h5432_edc4);
		expect_retire(0, 4'd9, 32'h0000_1234);
		test_name[1] = "forwarding";
		put_instr(1, encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h0005));
		put_instr(1, encode(OP_ADDI, 4'd1, 4'd1, 4'd0, 16'h0003));
		put_instr(1, encode(OP_ADD, 4'd2, 4'd1, 4'd1, 16'h0000));
		put_instr(1, encode(OP_SUB, 4'd3, 4'd2, 4'd1, 16'h0000));
		put_instr(1, encode(OP_ADDI, 4'd4, 4'd3, 4'd0, 16'hffff));
		put_instr(1, encode(OP_XOR, 4'd5, 4'd4, 4'd2, 16'h0000));
		put_instr(1, encode(OP_ADD, 4'd6, 4'd5, 4'd4, 16'h0000));
		expect_retire(1, 4'd1, 32'd5);
		expect_retire(1, 4'd1, 32'd8);
		expect_retire(1, 4'd2, 32'd16);
		expect_retire(1, 4'd3, 32'd8);
		expect_retire(1, 4'd4, 32'd7);
		expect_retire(1, 4'd5, 32'd23);
		expect_retire(1, 4'd6, 32'd30);
		// both branches are taken and skip the writes to r3, r4 and r6
		test_name[2] = "taken beq";
		put_instr(2, encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h0007));
		put_instr(2, encode(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'h0007));
		put_instr(2, encode(OP_BEQ, 4'd9, 4'd1, 4'd2, 16'h0002));
		put_instr(2, encode(OP_ADDI, 4'd3, 4'd0, 4'd0, 16'h0111));
		put_instr(2, encode(OP_ADDI, 4'd4, 4'd0, 4'd0, 16'h0222));
		put_instr(2, encode(OP_ADDI, 4'd5, 4'd1, 4'd0, 16'h0001));
		put_instr(2, encode(OP_BEQ, 4'd0, 4'd0, 4'd0, 16'h0001));
		put_instr(2, encode(OP_ADDI, 4'd6, 4'd0, 4'd0, 16'h0333));
		put_instr(2, encode(OP_ADD, 4'd7, 4'd5, 4'd2, 16'h0000));
		expect_retire(2, 4'd1, 32'd7);
		expect_retire(2, 4'd2, 32'd7);
		expect_retire(2, 4'd5, 32'd8);
		expect_retire(2, 4'd7, 32'd15);
		test_name[3] = "untaken beq";
		put_instr(3, encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h0001));
		put_instr(3, encode(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'h0002));
		put_instr(3, encode(OP_BEQ, 4'd10, 4'd1, 4'd2, 16'h0003));
		put_instr(3, encode(OP_ADDI, 4'd3, 4'd2, 4'd0, 16'h0010));
		put_instr(3, encode(OP_OR, 4'd4, 4'd1, 4'd2, 16'h0000));
		put_instr(3, encode(OP_BEQ, 4'd0, 4'd4, 4'd3, 16'h0001));
		put_instr(3, encode(OP_SUB, 4'd5, 4'd3, 4'd4, 16'h0000));
		expect_retire(3, 4'd1, 32'h01);
		expect_retire(3, 4'd2, 32'h02);
		expect_retire(3, 4'd3, 32'h12);
		expect_retire(3, 4'd4, 32'h03);
		expect_retire(3, 4'd5, 32'h0f);
	endtask

	// instruction memory, looks at the bus just after the rising edge
	// a delay of zero acks in the same cycle the strobe rises
	initial begin
		int delay_left;
		logic [31:0] rng;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		delay_left = -1;
		rng = 32'hf6b9;
		forever begin
			@(posedge clock);
			#1;
			if (wb_ack) begin
				wb_ack = 1'b0;   // the ack was taken at this edge
				delay_left = -1;
			end else if (!(wb_cyc && wb_stb)) begin
				delay_left = -1;   // no request, or one cut short by reset
			end else begin
				if (delay_left < 0) begin
					rng = xorshift32(rng);
					delay_left = int'(rng[1:0]);
				end
				if (delay_left == 0) begin
					wb_ack = 1'b1;
					wb_dat_i = mem_word(cur_test, wb_adr);
				end else begin
					delay_left--;
				end
			end
		end
	end

	task automatic run_test(input int t, input int round);
		int err_before;
		int got;
		int cycles;
		err_before = errors;
		@(posedge clock);
		#1;
		rst_n = 1'b0;
		repeat (8) begin
			@(negedge clock);
			checks++;
			assert (!wb_cyc && !retire_valid) else begin
				$display("CHECK FAILED at %0t: bus cycle or retire during reset", $time);
				errors++;
			end
		end
		cur_test = t;
		@(posedge clock);
		#1;
		rst_n = 1'b1;
		cycles = 0;
		while (!wb_cyc && cycles < START_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!wb_cyc) begin
			$display("%s: no bus cycle started within %0d cycles of reset", test_name[t],
				START_TIMEOUT);
			errors++;
		end else begin
			checks++;
			assert (wb_adr == PROG_BASE) else begin
				$display("CHECK FAILED at %0t: first fetch from %h, expected %h", $time, wb_adr,
					PROG_BASE);
				errors++;
			end
		end
		got = 0;
		cycles = 0;
		while (got < exp_cnt[t] && cycles < RETIRE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
			if (retire_valid) begin
				checks++;
				assert (retire_rd == exp_rd[t][got] && retire_data == exp_data[t][got]) else begin
					$display("CHECK FAILED at %0t: %s retire %0d is r%0d = %h, expected r%0d = %h",
						$time, test_name[t], got, retire_rd, retire_data, exp_rd[t][got],
						exp_data[t][got]);
					errors++;
				end
				got++;
			end
		end
		if (got < exp_cnt[t]) begin
			$display("%s: only %0d of %0d writes retired within %0d cycles", test_name[t], got,
				exp_cnt[t], RETIRE_TIMEOUT);
			errors++;
		end
		// the program has ended, so nothing may retire any more
		repeat (QUIET_CYCLES) begin
			@(negedge clock);
			checks++;
			assert (!retire_valid) else begin
				$display("CHECK FAILED at %0t: %s retired r%0d = %h after its last write", $time,
					test_name[t], retire_rd, retire_data);
				errors++;
			end
		end
		tests_run++;
		if (errors == err_before) begin
			$display("%-12s round %0d: %0d retires, ok", test_name[t], round, got);
		end else begin
			tests_failed++;
			$display("%-12s round %0d: %0d errors", test_name[t], round, errors - err_before);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		build_tables();
		// the second round meets other wait states from the same memory model
		for (int round = 0; round < 2; round++) begin
			for (int t = 0; t < N_TESTS; t++) begin
				run_test(t, round);
			end
		end
		$display("tests run %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tb_cpu_sva.sv */
`timescale 1ns/1ps

module tb_cpu_sva (
	input logic clock,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input cpu_pkg::word_t wb_adr,
	input logic wb_ack,
	input logic retire_valid,
	input cpu_pkg::reg_idx_t retire_rd
);

	stb_in_cyc: assert property (@(posedge clock) disable iff (!rst_n) wb_stb |-> wb_cyc)
		else $error("wb_stb high outside a bus cycle");

	// a request holds strobe and address until its ack
	stb_held: assert property (@(posedge clock) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
		else $error("wb_stb or wb_adr changed before wb_ack");

	stb_gap: assert property (@(posedge clock) disable iff (!rst_n)
		wb_stb && wb_ack |=> !wb_stb)
		else $error("wb_stb not dropped for a cycle after wb_ack");

	retire_rd_nonzero: assert property (@(posedge clock) disable iff (!rst_n)
		retire_valid |-> retire_rd != '0)
		else $error("retire reported for r0");

endmodule

bind cpu_top tb_cpu_sva u_sva (
	.clock(clock),
	.rst_n(rst_n),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_adr(wb_adr),
	.wb_ack(wb_ack),
	.retire_valid(retire_valid),
	.retire_rd(retire_rd)
);

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input logic clock,
	input logic rst_n,
	output logic wb_cyc,
	output logic wb_stb,
	output cpu_pkg::word_t wb_adr,
	input cpu_pkg::word_t wb_dat_i,
	input logic wb_ack,
	output logic retire_valid,
	output cpu_pkg::reg_idx_t retire_rd,
	output cpu_pkg::word_t retire_data
);
	import cpu_pkg::*;

	hazard_if hz ();

	if_id_t if_d;
	if_id_t if_q;
	id_ex_t id_d;
	id_ex_t id_q;
	ex_wb_t ex_d;
	ex_wb_t ex_q;
	logic if_id_clear;

	// a taken branch squashes both stages behind execute on the same edge
	assign hz.flush = hz.redirect;

	// with no word from fetch the IF/ID register takes a bubble
	assign if_id_clear = hz.flush || hz.stall;

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clock(clock),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.hz(hz.fetch),
		.out(if_d)
	);

	pipeline_reg #(
		.T(if_id_t)
	) u_if_id (
		.clock(clock),
		.rst_n(rst_n),
		.clear(if_id_clear),
		.stall(1'b0),
		.d(if_d),
		.q(if_q)
	);

	decode_stage u_decode (
		.clock(clock),
		.rst_n(rst_n),
		.in(if_q),
		.ex_fwd(ex_d),      // live result of the instruction in execute
		.wb(ex_q),
		.out(id_d)
	);

	pipeline_reg #(
		.T(id_ex_t)
	) u_id_ex (
		.clock(clock),
		.rst_n(rst_n),
		.clear(hz.flush),
		.stall(1'b0),
		.d(id_d),
		.q(id_q)
	);

	execute_stage u_execute (
		.in(id_q),
		.hz(hz.exec),
		.out(ex_d)
	);

	// the branch that flushes is itself in execute, so EX/WB never clears
	pipeline_reg #(
		.T(ex_wb_t)
	) u_ex_wb (
		.clock(clock),
		.rst_n(rst_n),
		.clear(1'b0),
		.stall(1'b0),
		.d(ex_d),
		.q(ex_q)
	);

	assign retire_valid = ex_q.valid && (ex_q.rd != '0);
	assign retire_rd = ex_q.rd;
	assign retire_data = ex_q.result;

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input cpu_pkg::id_ex_t in,
	hazard_if.exec hz,
	output cpu_pkg::ex_wb_t out
);
	import cpu_pkg::*;

	logic is_beq;
	logic taken;

	assign is_beq = in.valid && (in.op == OP_BEQ);
	assign taken = is_beq && (in.a == in.cmp);

	// the branch compares rs with rt
	assign hz.redirect = taken;
	assign hz.target = in.target;

	always_comb begin
		out.valid = in.valid && writes_rd(in.op);   // BEQ and NOP leave the register file alone
		out.rd = in.rd;
		out.result = alu(in.op, in.a, in.b);
	end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input logic clock,
	input logic rst_n,
	input cpu_pkg::if_id_t in,
	input cpu_pkg::ex_wb_t ex_fwd,
	input cpu_pkg::ex_wb_t wb,
	output cpu_pkg::id_ex_t out
);
	import cpu_pkg::*;

	word_t regs [16];
	instr_t ins;
	word_t imm_ext;
	word_t rs_val;
	word_t rt_val;

	// youngest producer first, then the one about to write, then the file
	function automatic word_t pick(reg_idx_t idx, ex_wb_t ex, ex_wb_t wr, word_t rf);
		if (idx == '0) begin
			return '0;
		end
		if (ex.valid && ex.rd == idx) begin
			return ex.result;
		end
		if (wr.valid && wr.rd == idx) begin
			return wr.result;
		end
		return rf;
	endfunction

	// r0 is never written so it stays zero from reset on
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && wb.rd != '0) begin
			regs[wb.rd] <= wb.result;
		end
	end

	assign ins = instr_t'(in.instr);
	assign imm_ext = sext16(ins.imm);

	always_comb begin
		rs_val = pick(ins.rs, ex_fwd, wb, regs[ins.rs]);
		rt_val = pick(ins.rt, ex_fwd, wb, regs[ins.rt]);
	end

	always_comb begin
		out.valid = in.valid;
		out.op = ins.op;
		out.rd = ins.rd;
		out.a = rs_val;
		out.b = uses_imm(ins.op) ? imm_ext : rt_val;
		out.cmp = rt_val;
		out.target = in.pc + 32'd1 + imm_ext;   // relative to the next word
	end

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input logic clock,
	input logic rst_n,
	output logic wb_cyc,
	output logic wb_stb,
	output cpu_pkg::word_t wb_adr,
	input cpu_pkg::word_t wb_dat_i,
	input logic wb_ack,
	hazard_if.fetch hz,
	output cpu_pkg::if_id_t out
);
	import cpu_pkg::*;

	word_t pc;          // next address to fetch
	word_t adr;         // address of the transfer in flight
	logic busy;
	logic stale;        // a redirect came while this transfer was open
	word_t start_adr;
	logic word_ok;

	assign start_adr = hz.redirect ? hz.target : pc;

	// a word acked in the redirect cycle is younger than the branch
	assign word_ok = busy && wb_ack && !stale && !hz.redirect;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			adr <= RESET_PC;
			busy <= 1'b0;
			stale <= 1'b0;
		end else if (!busy) begin
			// the cycle after an ack keeps stb low
			busy <= 1'b1;
			adr <= start_adr;
			pc <= start_adr + 32'd1;
		end else if (wb_ack) begin
			busy <= 1'b0;
			stale <= 1'b0;
			if (hz.redirect) begin
				pc <= hz.target;
			end
		end else if (hz.redirect) begin
			stale <= 1'b1;      // let the bus finish and drop the data on ack
			pc <= hz.target;
		end
	end

	assign wb_cyc = busy;
	assign wb_stb = busy;
	assign wb_adr = adr;

	always_comb begin
		out.valid = word_ok;
		out.pc = adr;
		out.instr = wb_dat_i;
	end

	assign hz.stall = !word_ok;

endmodule

/* pipeline_reg.sv */
`timescale 1ns/1ps

module pipeline_reg #(
	parameter type T = logic [31:0]
) (
	input logic clock,
	input logic rst_n,
	input logic clear,
	input logic stall,
	input T d,
	output T q
);

	// an all zero payload has its valid bit low, so zero is a bubble
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (clear) begin
			q <= '0;   // clear wins over stall
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

/* hazard_if.sv */
`timescale 1ns/1ps

interface hazard_if;
	import cpu_pkg::*;

	logic redirect;   // taken BEQ in execute, high for one cycle
	word_t target;
	logic flush;
	logic stall;      // no fetched word this cycle

	// execute raises the redirect and fetch follows it
	modport fetch (
		input redirect,
		input target,
		output stall
	);

	modport exec (
		output redirect,
		output target
	);

	// view of the stage registers
	modport regs (
		input flush,
		input stall
	);

endinterface

/* cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_ADDI = 4'h6,
		OP_LUI  = 4'h7,
		OP_BEQ  = 4'h8
	} opcode_t;

	// instruction word layout from msb down to bit 0
	typedef struct packed {
		opcode_t op;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		logic [15:0] imm;
	} instr_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		opcode_t op;
		reg_idx_t rd;
		word_t a;
		word_t b;      // rt value or the extended immediate
		word_t cmp;    // rt value for the BEQ compare
		word_t target;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		word_t result;
	} ex_wb_t;

	function automatic word_t sext16(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	// ADDI and LUI take the immediate as operand b
	function automatic logic uses_imm(opcode_t op);
		return (op == OP_ADDI) || (op == OP_LUI);
	endfunction

	function automatic logic writes_rd(opcode_t op);
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LUI: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t alu(opcode_t op, word_t a, word_t b);
		case (op)
			OP_ADD, OP_ADDI: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_LUI: return {b[15:0], 16'h0000}; // only the low half of b is the immediate
			default: return '0;
		endcase
	endfunction

endpackage
